// File: Makefile
SIM      = verilator
TOP      = tb_ldpc_dec
FILELIST = ldpc_dec_top.f
FLAGS    = --binary --timing --assert -Wno-fatal
RUNARGS  = +verilator+error+limit+1000
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: check_node_unit.sv
module check_node_unit import ldpc_dec_pkg::*; (
  input  logic iclk,
  input  logic ireset,
  node_if.cnu  nodes
);

  msg_t c2v_next [cN_CHECKS][cN_BITS];

  // |v|, -32 maps to 32 which still fits unsigned
  function automatic logic [cMSG_W-1 : 0] mag_of(input msg_t v);
    logic [cMSG_W-1 : 0] m;
    m = v[cMSG_W-1] ? cMSG_W'(-v) : cMSG_W'(v);
    return m;
  endfunction

  //------------------------------------------------------------
  // min-sum over the other edges of each row
  //------------------------------------------------------------

  always_comb begin
    logic                 sgn;
    logic [cMSG_W-1 : 0]  mag_min;
    logic [cPROD_W-1 : 0] prod;
    logic [cPROD_W-1 : 0] norm;
    for (int r = 0; r < cN_CHECKS; r++) begin
      for (int c = 0; c < cN_BITS; c++) begin
        sgn     = 1'b0;
        mag_min = '1;
        for (int k = 0; k < cN_BITS; k++) begin
          if (cH_MATRIX[r][k] && k != c) begin  // extrinsic, skip own edge
            sgn = sgn ^ nodes.v2c[r][k][cMSG_W-1];
            if (mag_of(nodes.v2c[r][k]) < mag_min) begin
              mag_min = mag_of(nodes.v2c[r][k]);
            end
          end
        end
        // normalize mag * 7 >> 3
        prod = cPROD_W'(mag_min) * cPROD_W'(cNORM_MUL);
        norm = prod >> cNORM_SHIFT;
        if (norm > cPROD_W'(cMSG_MAX)) begin
          norm = cPROD_W'(cMSG_MAX);   // clip
        end
        if (!cH_MATRIX[r][c]) begin
          c2v_next[r][c] = '0;         // no edge
        end
        else if (sgn) begin
          c2v_next[r][c] = -msg_t'(norm);
        end
        else begin
          c2v_next[r][c] = msg_t'(norm);
        end
      end
    end
  end

  // message register, cleared per frame
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      nodes.c2v <= '{default: '0};
    end
    else if (nodes.init) begin
      nodes.c2v <= '{default: '0};
    end
    else if (nodes.check_en) begin
      nodes.c2v <= c2v_next;
    end
  end

endmodule

// File: decode_ctrl.sv
module decode_ctrl import ldpc_dec_pkg::*; (
  input  logic  iclk,
  input  logic  ireset,
  frame_if.dst  in_bus,
  node_if.ctrl  nodes,
  output llr_t  frame_llr [cN_BITS],
  output logic  dec_valid,
  input  logic  dec_ready,
  output bits_t dec_bits,
  output logic  dec_fail,
  output err_t  bit_err,
  output iter_t iter_used
);

  dec_state_t state;
  iter_t      iter_cnt;   // iterations finished
  iter_t      niter_q;
  logic       fmode_q;
  logic       init_q;     // one cycle after frame accept

  logic       take;
  logic       stop;
  bits_t      in_sign;
  err_t       err_cnt;

  assign in_bus.ready = (state == st_idle);
  assign take         = in_bus.valid & in_bus.ready;

  // limit reached, or fast mode with clean syndrome after >= 1 iteration
  assign stop = (iter_cnt == niter_q) ||
                (fmode_q && nodes.syndrome_ok && iter_cnt != '0);

  // strobes, init waits one cycle for vnu totals
  assign nodes.init     = init_q;
  assign nodes.check_en = (state == st_check) && !init_q && !stop;
  assign nodes.var_en   = (state == st_var);

  // bit errors vs channel hard decision
  always_comb begin
    err_cnt = '0;
    for (int i = 0; i < cN_BITS; i++) begin
      in_sign[i] = frame_llr[i][cLLR_W-1];
      err_cnt    = err_cnt + err_t'(nodes.hard[i] ^ in_sign[i]);
    end
  end

  //------------------------------------------------------------
  // iteration FSM
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= st_idle;
      iter_cnt  <= '0;
      init_q    <= 1'b0;
      dec_valid <= 1'b0;
    end
    else begin
      init_q <= take;
      case (state)
        st_idle : if (take) begin
          iter_cnt <= '0;
          state    <= st_check;
        end
        st_check : if (!init_q) begin
          if (stop) begin
            dec_valid <= 1'b1;
            state     <= st_done;
          end
          else begin
            state <= st_var;
          end
        end
        st_var : begin
          iter_cnt <= iter_cnt + 1'b1;
          state    <= st_check;  // stop test sees fresh syndrome
        end
        st_done : if (dec_ready) begin  // hold until sink takes it
          dec_valid <= 1'b0;
          state     <= st_idle;
        end
        default : state <= st_idle;
      endcase
    end
  end

  // frame and result payload
  always_ff @(posedge iclk) begin
    if (take) begin
      frame_llr <= in_bus.llr;
      niter_q   <= in_bus.niter;
      fmode_q   <= in_bus.fmode;
    end
    if (state == st_check && !init_q && stop) begin
      dec_bits  <= nodes.hard;
      dec_fail  <= ~nodes.syndrome_ok;
      bit_err   <= err_cnt;
      iter_used <= iter_cnt;
    end
  end

endmodule

// File: frame_if.sv
// one whole llr frame plus its decode settings, valid/ready
interface frame_if import ldpc_dec_pkg::*; ();

  logic  valid;
  logic  ready;
  llr_t  llr [cN_BITS];  // index = code bit
  iter_t niter;          // max iterations
  logic  fmode;          // early stop on clean syndrome

  // producer side, fields held while valid & !ready
  modport src (
    output valid,
    output llr,
    output niter,
    output fmode,
    input  ready
  );

  modport dst (
    input  valid,
    input  llr,
    input  niter,
    input  fmode,
    output ready
  );

endinterface

// File: ldpc_dec_asserts.sv
module ldpc_dec_asserts import ldpc_dec_pkg::*; (
  input logic  iclk,
  input logic  ireset,
  input logic  llr_valid,
  input logic  llr_ready,
  input logic  dec_valid,
  input logic  dec_ready,
  input bits_t dec_bits,
  input logic  dec_fail,
  input err_t  bit_err,
  input iter_t iter_used,
  input logic  exp_valid,  // a result is owed
  input bits_t exp_bits,
  input logic  exp_fail,
  input err_t  exp_err,
  input iter_t exp_iter
);
  timeunit 1ns;
  timeprecision 100ps;

  int                   fail_cnt = 0;  // failed checks so far
  logic [cBEAT_W-1 : 0] beat_cnt;
  int                   in_flight;     // frames loaded, result not yet taken

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat_cnt  <= '0;
      in_flight <= 0;
    end
    else begin
      if (llr_valid && llr_ready) beat_cnt <= beat_cnt + cBEAT_W'(1);
      in_flight <= in_flight
                 + ((llr_valid && llr_ready && beat_cnt == cBEAT_W'(cN_BITS - 1)) ? 1 : 0)
                 - ((dec_valid && dec_ready) ? 1 : 0);
    end
  end

  //------------------------------------------------------------
  // result, handshake and reset checks
  //------------------------------------------------------------

  a_reset : assert property (@(posedge iclk) ireset |-> !dec_valid)
    else begin
      fail_cnt++;
      $error("dec_valid high during reset");
    end

  a_early : assert property (@(posedge iclk) disable iff (ireset) dec_valid |-> in_flight > 0)
    else begin
      fail_cnt++;
      $error("dec_valid rose with no frame loaded");
    end

  a_no_exp : assert property (@(posedge iclk) disable iff (ireset) dec_valid |-> exp_valid)
    else begin
      fail_cnt++;
      $error("result came out with no frame outstanding");
    end

  a_result : assert property (@(posedge iclk) disable iff (ireset)
      dec_valid && exp_valid |-> dec_bits == exp_bits && dec_fail == exp_fail &&
                                 bit_err == exp_err && iter_used == exp_iter)
    else begin
      fail_cnt++;
      $error("ERROR %0t: bits %b fail %b err %0d iter %0d, expected %b %b %0d %0d", $time,
             $sampled(dec_bits), $sampled(dec_fail), $sampled(bit_err), $sampled(iter_used),
             $sampled(exp_bits), $sampled(exp_fail), $sampled(exp_err), $sampled(exp_iter));
    end

  // stalled result must not move
  a_hold : assert property (@(posedge iclk) disable iff (ireset)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec_bits) && $stable(dec_fail) &&
                                  $stable(bit_err) && $stable(iter_used))
    else begin
      fail_cnt++;
      $error("result changed or dropped while stalled");
    end

  // decoder, both buffer slots and loader all occupied
  a_full : assert property (@(posedge iclk) disable iff (ireset) in_flight >= 4 |-> !llr_ready)
    else begin
      fail_cnt++;
      $error("llr_ready high with every frame slot full");
    end

endmodule

// File: ldpc_dec_pkg.sv
package ldpc_dec_pkg;

  //------------------------------------------------------------
  // code and datapath widths
  //------------------------------------------------------------

  localparam int cN_BITS     = 8;   // code length
  localparam int cN_CHECKS   = 4;   // parity checks
  localparam int cLLR_W      = 6;
  localparam int cMSG_W      = 6;
  localparam int cSUM_W      = 9;   // llr + all check messages, no overflow
  localparam int cITER_W     = 4;
  localparam int cERR_W      = 4;

  localparam int cBEAT_W     = $clog2(cN_BITS);  // serial beat counter
  localparam int cBUF_DEPTH  = 2;                // frames in flight
  localparam int cBUF_CNT_W  = $clog2(cBUF_DEPTH + 1);

  // normalized min-sum, mag * 7 / 8
  localparam int cNORM_MUL   = 7;
  localparam int cNORM_SHIFT = 3;
  localparam int cPROD_W     = cMSG_W + 3;       // magnitude times cNORM_MUL
  localparam int cMSG_MAX    = 31;               // symmetric message clip

  //------------------------------------------------------------
  // types
  //------------------------------------------------------------

  typedef logic signed [cLLR_W-1 : 0] llr_t;
  typedef logic signed [cMSG_W-1 : 0] msg_t;
  typedef logic signed [cSUM_W-1 : 0] sum_t;
  typedef logic        [cN_BITS-1 : 0] bits_t;
  typedef logic        [cITER_W-1 : 0] iter_t;
  typedef logic        [cERR_W-1 : 0] err_t;

  typedef enum logic [1 : 0] {
    st_idle,   // waiting for a frame
    st_check,  // check node pass or stop decision
    st_var,    // variable node pass
    st_done    // result held for the sink
  } dec_state_t;

  //------------------------------------------------------------
  // (8,4) extended hamming parity check matrix
  //------------------------------------------------------------

  // bit i of a row is code bit i, column i is {i[2], i[1], i[0], ~i[0]}
  // so all ones overall parity row = row 0 ^ row 3, every row weight 4
  localparam bits_t cH_MATRIX [cN_CHECKS] = '{
    8'b1010_1010,  // i[0]
    8'b1100_1100,  // i[1]
    8'b1111_0000,  // i[2]
    8'b0101_0101   // ~i[0]
  };

endpackage

// File: ldpc_dec_top.f
ldpc_dec_pkg.sv
frame_if.sv
node_if.sv
llr_loader.sv
llr_frame_buf.sv
check_node_unit.sv
var_node_unit.sv
decode_ctrl.sv
ldpc_dec_top.sv
ldpc_dec_asserts.sv
tb_ldpc_dec.sv

// File: ldpc_dec_top.sv
module ldpc_dec_top import ldpc_dec_pkg::*; (
  input  logic  iclk,
  input  logic  ireset,
  // serial llr input, one llr per beat
  input  logic  llr_valid,
  output logic  llr_ready,
  input  llr_t  llr,
  input  iter_t niter,     // sampled on beat 0
  input  logic  fmode,
  // one result per frame
  output logic  dec_valid,
  input  logic  dec_ready,
  output bits_t dec_bits,
  output logic  dec_fail,
  output err_t  bit_err,
  output iter_t iter_used
);

  frame_if load_bus ();   // loader -> buffer
  frame_if dec_bus ();    // buffer -> decoder
  node_if  nodes ();

  llr_t    frame_llr [cN_BITS];  // frame under decode

  //------------------------------------------------------------
  // input side
  //------------------------------------------------------------

  llr_loader loader (
    .iclk      ( iclk      ),
    .ireset    ( ireset    ),
    .llr_valid ( llr_valid ),
    .llr_ready ( llr_ready ),
    .llr       ( llr       ),
    .niter     ( niter     ),
    .fmode     ( fmode     ),
    .out_bus   ( load_bus  )
  );

  llr_frame_buf frame_buf (.iclk(iclk), .ireset(ireset), .in_bus(load_bus), .out_bus(dec_bus));

  //------------------------------------------------------------
  // decoder
  //------------------------------------------------------------

  decode_ctrl ctrl (
    .iclk      ( iclk      ),
    .ireset    ( ireset    ),
    .in_bus    ( dec_bus   ),
    .nodes     ( nodes     ),
    .frame_llr ( frame_llr ),
    .dec_valid ( dec_valid ),
    .dec_ready ( dec_ready ),
    .dec_bits  ( dec_bits  ),
    .dec_fail  ( dec_fail  ),
    .bit_err   ( bit_err   ),
    .iter_used ( iter_used )
  );

  check_node_unit cnode (.iclk(iclk), .ireset(ireset), .nodes(nodes));

  var_node_unit vnode (.iclk(iclk), .ireset(ireset), .llr(frame_llr), .nodes(nodes));

endmodule

// File: llr_frame_buf.sv
module llr_frame_buf import ldpc_dec_pkg::*; (
  input  logic iclk,
  input  logic ireset,
  frame_if.dst in_bus,
  frame_if.src out_bus
);

  // frame storage, no reset needed
  llr_t  mem_llr   [cBUF_DEPTH][cN_BITS];
  iter_t mem_niter [cBUF_DEPTH];
  logic  mem_fmode [cBUF_DEPTH];

  logic                    wr_ptr;  // depth 2, pointers wrap by themselves
  logic                    rd_ptr;
  logic [cBUF_CNT_W-1 : 0] count;

  logic                    wr;
  logic                    rd;

  assign in_bus.ready = (count < cBUF_CNT_W'(cBUF_DEPTH));  // own count only
  assign out_bus.valid = (count != '0);

  assign wr = in_bus.valid & in_bus.ready;
  assign rd = out_bus.valid & out_bus.ready;

  //------------------------------------------------------------
  // pointers and fill level
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end
    else begin
      if (wr) wr_ptr <= ~wr_ptr;
      if (rd) rd_ptr <= ~rd_ptr;
      case ({wr, rd})
        2'b10   : count <= count + 1'b1;
        2'b01   : count <= count - 1'b1;
        default : count <= count;  // both or none
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (wr) begin
      mem_llr  [wr_ptr] <= in_bus.llr;
      mem_niter[wr_ptr] <= in_bus.niter;
      mem_fmode[wr_ptr] <= in_bus.fmode;
    end
  end

  // head entry, stable until popped
  assign out_bus.llr   = mem_llr  [rd_ptr];
  assign out_bus.niter = mem_niter[rd_ptr];
  assign out_bus.fmode = mem_fmode[rd_ptr];

endmodule

// File: llr_loader.sv
module llr_loader import ldpc_dec_pkg::*; (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  llr_valid,
  output logic  llr_ready,
  input  llr_t  llr,
  input  iter_t niter,
  input  logic  fmode,
  frame_if.src  out_bus
);

  logic [cBEAT_W-1 : 0] beat_cnt;
  logic                 frame_val;   // finished frame on offer
  llr_t                 frame_llr [cN_BITS];
  iter_t                niter_q;
  logic                 fmode_q;

  logic                 beat;

  assign llr_ready = ~frame_val;  // stall only while frame is waiting
  assign beat      = llr_valid & llr_ready;

  //------------------------------------------------------------
  // beat counter and frame valid
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat_cnt  <= '0;
      frame_val <= 1'b0;
    end
    else begin
      if (beat) begin
        beat_cnt <= beat_cnt + 1'b1;  // wraps after last beat
      end
      if (beat && beat_cnt == cBEAT_W'(cN_BITS - 1)) begin
        frame_val <= 1'b1;   // offered next cycle
      end
      else if (out_bus.ready) begin
        frame_val <= 1'b0;
      end
    end
  end

  // shift down, first beat ends up in bit 0
  always_ff @(posedge iclk) begin
    if (beat) begin
      frame_llr[cN_BITS-1] <= llr;
      for (int i = 0; i < cN_BITS - 1; i++) begin
        frame_llr[i] <= frame_llr[i+1];
      end
      if (beat_cnt == '0) begin
        niter_q <= niter;  // settings come with beat 0
        fmode_q <= fmode;
      end
    end
  end

  assign out_bus.valid = frame_val;
  assign out_bus.llr   = frame_llr;
  assign out_bus.niter = niter_q;
  assign out_bus.fmode = fmode_q;

endmodule

// File: node_if.sv
// message exchange between controller, check and variable node units
interface node_if import ldpc_dec_pkg::*; ();

  logic  check_en;                      // one cycle check node update
  logic  var_en;                        // one cycle variable node update
  logic  init;                          // load new frame, clear messages
  msg_t  c2v [cN_CHECKS][cN_BITS];      // check to variable
  msg_t  v2c [cN_CHECKS][cN_BITS];      // variable to check
  bits_t hard;                          // current hard decision
  logic  syndrome_ok;                   // hard bits satisfy all rows

  modport ctrl (
    output check_en, var_en, init,
    input  hard, syndrome_ok
  );

  modport cnu (
    input  check_en, init, v2c,
    output c2v
  );

  modport vnu (
    input  var_en, init, c2v,
    output v2c, hard, syndrome_ok
  );

endinterface

// File: tb_ldpc_dec.sv
module tb_ldpc_dec import ldpc_dec_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cNUM_FRAMES = 36;                       // 24 directed, 12 under heavy stall
  localparam int cWATCHDOG   = cNUM_FRAMES * 200 + 1000; // cycles

  // owed results wait in exp_q oldest first
  typedef struct packed {
    bits_t bits;
    logic  fail;
    err_t  err;
    iter_t iter;
  } exp_t;

  logic  iclk = 1'b0;
  logic  ireset;
  logic  llr_valid;
  logic  llr_ready;
  llr_t  llr;
  iter_t niter;
  logic  fmode;
  logic  dec_valid;
  logic  dec_ready;
  bits_t dec_bits;
  logic  dec_fail;
  err_t  bit_err;
  iter_t iter_used;

  logic [31:0] lfsr = 32'd91661;  // galois lfsr for stimulus and stalls
  logic        heavy_stall;       // ready one cycle in eight
  llr_t        frame [cN_BITS];   // next frame to send by code bit index
  bits_t       cw_list [$];       // every codeword of H
  exp_t        exp_q [$];
  bits_t       exp_bits;          // queue head as seen by the checker
  logic        exp_fail;
  err_t        exp_err;
  iter_t       exp_iter;
  logic        exp_valid;
  int          errors;

  always #20 iclk = ~iclk;

  ldpc_dec_top ldpc_dec_top_inst (
    .iclk      ( iclk      ),
    .ireset    ( ireset    ),
    .llr_valid ( llr_valid ),
    .llr_ready ( llr_ready ),
    .llr       ( llr       ),
    .niter     ( niter     ),
    .fmode     ( fmode     ),
    .dec_valid ( dec_valid ),
    .dec_ready ( dec_ready ),
    .dec_bits  ( dec_bits  ),
    .dec_fail  ( dec_fail  ),
    .bit_err   ( bit_err   ),
    .iter_used ( iter_used )
  );

  bind ldpc_dec_top ldpc_dec_asserts chk (
    .iclk      ( iclk                  ),
    .ireset    ( ireset                ),
    .llr_valid ( llr_valid             ),
    .llr_ready ( llr_ready             ),
    .dec_valid ( dec_valid             ),
    .dec_ready ( dec_ready             ),
    .dec_bits  ( dec_bits              ),
    .dec_fail  ( dec_fail              ),
    .bit_err   ( bit_err               ),
    .iter_used ( iter_used             ),
    .exp_valid ( tb_ldpc_dec.exp_valid ),
    .exp_bits  ( tb_ldpc_dec.exp_bits  ),
    .exp_fail  ( tb_ldpc_dec.exp_fail  ),
    .exp_err   ( tb_ldpc_dec.exp_err   ),
    .exp_iter  ( tb_ldpc_dec.exp_iter  )
  );

  //------------------------------------------------------------
  // random bits and reference rules
  //------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // any row of H holding an odd number of ones
  function automatic logic violates_parity(input bits_t b);
    int   ones;
    logic v;
    v = 1'b0;
    for (int r = 0; r < cN_CHECKS; r++) begin
      ones = 0;
      for (int i = 0; i < cN_BITS; i++) begin
        if (cH_MATRIX[r][i] && b[i]) ones++;
      end
      if (ones % 2 != 0) v = 1'b1;
    end
    return v;
  endfunction

  // bit 1 gives a negative llr and flip marks one weak wrong-sign bit (-1 for none)
  task automatic build_llrs(input bits_t cw, input int flip);
    llr_t mag;
    for (int i = 0; i < cN_BITS; i++) begin
      mag      = (i == flip) ? llr_t'(2) : llr_t'(20);
      frame[i] = (cw[i] ^ (i == flip)) ? -mag : mag;
    end
  endtask

  // eight beats entered and left 2 ns after a rising edge
  task automatic send_frame(input iter_t n, input logic fm, input exp_t e);
    int   i;
    logic acc;
    exp_q.push_back(e);
    i = 0;
    while (i < cN_BITS) begin
      llr_valid = 1'b1;
      llr       = frame[i];
      niter     = n;
      fmode     = fm;
      acc       = llr_ready;  // register output stays stable till the edge
      @(posedge iclk);
      #2;
      if (acc) i++;
    end
    llr_valid = 1'b0;
  endtask

  task automatic send_kind(input int kind);
    bits_t cw;
    bits_t sg;
    cw = cw_list[take_bits(4) % cw_list.size()];
    case (kind)
      0 : begin  // clean codeword runs all iterations
        build_llrs(cw, -1);
        send_frame(4'd4, 1'b0, {cw, 1'b0, 4'd0, 4'd4});
      end
      1 : begin  // clean codeword stops after the first pass
        build_llrs(cw, -1);
        send_frame(4'd4, 1'b1, {cw, 1'b0, 4'd0, 4'd1});
      end
      2 : begin  // one weak flipped bit gets corrected
        build_llrs(cw, int'(take_bits(3)));
        send_frame(4'd3, 1'b0, {cw, 1'b0, 4'd1, 4'd3});
      end
      default : begin  // zero iterations give the raw signs
        for (int i = 0; i < cN_BITS; i++) begin
          frame[i] = llr_t'(take_bits(6));
          sg[i]    = frame[i][cLLR_W-1];
        end
        send_frame(4'd0, 1'b0, {sg, violates_parity(sg), 4'd0, 4'd0});
      end
    endcase
  endtask

  //------------------------------------------------------------
  // scoreboard head, sink stalls, watchdog
  //------------------------------------------------------------

  always @(posedge iclk) begin
    if (dec_valid && dec_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());  // result taken this edge
    end
    exp_valid <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_bits <= exp_q[0].bits;
      exp_fail <= exp_q[0].fail;
      exp_err  <= exp_q[0].err;
      exp_iter <= exp_q[0].iter;
    end
  end

  // ready drawn at the edge and applied 2 ns later
  always @(posedge iclk) begin
    logic [7:0] r;
    logic       rdy;
    r   = take_bits(3);
    rdy = heavy_stall ? (r[2:0] == 3'b111) : r[0];
    #2;
    dec_ready = rdy;
  end

  initial begin
    repeat (cWATCHDOG) @(posedge iclk);
    $display("timeout: results stopped arriving within %0d cycles", cWATCHDOG);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    ireset      = 1'b1;
    llr_valid   = 1'b0;
    llr         = '0;
    niter       = '0;
    fmode       = 1'b0;
    dec_ready   = 1'b0;
    heavy_stall = 1'b0;
    for (int w = 0; w < 256; w++) begin
      if (!violates_parity(bits_t'(w))) cw_list.push_back(bits_t'(w));
    end
    repeat (10) @(posedge iclk);
    #2;
    ireset = 1'b0;
    repeat (2) @(posedge iclk);
    #2;
    for (int k = 0; k < 24; k++) send_kind(k / 6);  // six of each kind
    heavy_stall = 1'b1;  // sink mostly stalled so buffer and loader fill up
    for (int k = 0; k < cNUM_FRAMES - 24; k++) send_kind(k % 4);
    while (exp_q.size() != 0) begin
      @(posedge iclk);
      #2;
    end
    repeat (4) @(posedge iclk);
    errors = ldpc_dec_top_inst.chk.fail_cnt;
    $display("done: %0d frames, %0d errors", cNUM_FRAMES, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end
    else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: var_node_unit.sv
module var_node_unit import ldpc_dec_pkg::*; (
  input  logic iclk,
  input  logic ireset,
  input  llr_t llr [cN_BITS],
  node_if.vnu  nodes
);

  llr_t                   llr_q     [cN_BITS];      // channel llr of this frame
  msg_t                   c2v_in    [cN_CHECKS][cN_BITS];
  sum_t                   total     [cN_BITS];
  msg_t                   v2c_next  [cN_CHECKS][cN_BITS];
  bits_t                  hard_next;
  logic [cN_CHECKS-1 : 0] row_par;

  // clip a total to the message range
  function automatic msg_t sat_msg(input sum_t s);
    msg_t m;
    if (s > sum_t'(cMSG_MAX))       m = msg_t'(cMSG_MAX);
    else if (s < -sum_t'(cMSG_MAX)) m = -msg_t'(cMSG_MAX);
    else                            m = msg_t'(s);
    return m;
  endfunction

  //------------------------------------------------------------
  // totals, extrinsic messages, hard bits, syndrome
  //------------------------------------------------------------

  always_comb begin
    for (int r = 0; r < cN_CHECKS; r++) begin
      for (int c = 0; c < cN_BITS; c++) begin
        c2v_in[r][c] = nodes.init ? msg_t'(0) : nodes.c2v[r][c];  // fresh frame
      end
    end
    for (int c = 0; c < cN_BITS; c++) begin
      total[c] = sum_t'(nodes.init ? llr[c] : llr_q[c]);
      for (int r = 0; r < cN_CHECKS; r++) begin
        if (cH_MATRIX[r][c]) total[c] = total[c] + sum_t'(c2v_in[r][c]);
      end
      hard_next[c] = total[c][cSUM_W-1];  // negative total -> 1
    end
    for (int r = 0; r < cN_CHECKS; r++) begin
      for (int c = 0; c < cN_BITS; c++) begin
        v2c_next[r][c] = cH_MATRIX[r][c] ? sat_msg(total[c] - sum_t'(c2v_in[r][c]))
                                         : msg_t'(0);
      end
      row_par[r] = ^(hard_next & cH_MATRIX[r]);  // even parity per row
    end
  end

  always_ff @(posedge iclk) begin
    if (nodes.init) llr_q <= llr;
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      nodes.v2c         <= '{default: '0};
      nodes.hard        <= '0;
      nodes.syndrome_ok <= 1'b0;
    end
    else if (nodes.init || nodes.var_en) begin
      nodes.v2c         <= v2c_next;
      nodes.hard        <= hard_next;
      nodes.syndrome_ok <= (row_par == '0);
    end
  end

endmodule
